// ==== common/memCtl_macros.svh ====
`ifndef MEMCTL_MACROS_SVH
`define MEMCTL_MACROS_SVH

// Microword and datapath field widths
`define MEM_FUNC_W 4
`define MAGIC_W 9
`define SECTION_W 12
`define OFFSET_W 18
`define VMA_W (`SECTION_W + `OFFSET_W)
`define AD_W 36
`define STATUS_W 12

// Memory function codes, also the one-hot bit positions
`define MEM_NOP 0
`define MEM_READ 1
`define MEM_WRITE 2
`define MEM_RPW 3
`define MEM_FETCH 4
`define MEM_COND_FETCH 5
`define MEM_EA_CALC 6
`define MEM_AD_FUNC 7
`define MEM_SPEC 8
`define FUNC_CNT 9

// Sections actually implemented
`define SECTION_LIMIT 32

// AD word bits read by the AD function
`define AD_READ 34
`define AD_WRITE 33
`define AD_PAUSE 32
`define AD_USER 31
`define AD_PUBLIC 30
`define AD_LONG 27

`endif

// ==== common/memCtlPkg.sv ====
`default_nettype none

`include "memCtl_macros.svh"

package memCtlPkg;

  // Magic field as seen by an EA-calc function
  typedef struct packed {
    logic longEn;
    logic prevEn;
    logic extFlag;
    logic [`MAGIC_W-4:0] unused;
  } magicEaT;

  // Magic field as seen by a special memory cycle
  typedef struct packed {
    logic execCycle;
    logic physRef;
    logic userTable;
    logic [`MAGIC_W-4:0] unused;
  } magicSpecT;

  // Same nine bits, decoded per memory function
  typedef union packed {
    magicEaT ea;
    magicSpecT spec;
  } magicU;

endpackage

`default_nettype wire

// ==== logic/memFuncDecode.sv ====
`default_nettype none

`include "memCtl_macros.svh"

module memFuncDecode (
  input  logic clk,
  input  logic rstN,
  input  logic uwValid,
  output logic uwReady,
  input  logic [`MEM_FUNC_W-1:0] memField,
  input  memCtlPkg::magicU magic,
  input  logic [`AD_W-1:0] adWord,
  input  logic [`VMA_W-1:0] vma,
  input  logic testSatisfied,
  input  logic userMode,
  input  logic publicMode,
  input  logic prevEnable,
  input  logic [`SECTION_W-1:0] pcSection,
  output logic decValid,
  input  logic decReady,
  output logic [`FUNC_CNT-1:0] funcOneHot,
  output memCtlPkg::magicU decMagic,
  output logic [`AD_W-1:0] decAdWord,
  output logic [`VMA_W-1:0] decVma,
  output logic decUserMode,
  output logic decPublicMode,
  output logic decPrevEnable,
  output logic [`SECTION_W-1:0] decPcSection
);

  logic [`FUNC_CNT-1:0] oneHotNext;
  logic accept;

  assign uwReady = ~decValid | decReady;
  assign accept = uwValid & uwReady;

  always_comb begin
    for (int i = 0; i < `FUNC_CNT; i++) begin
      oneHotNext[i] = (memField == `MEM_FUNC_W'(i));
    end
    // Unused codes act as NOP
    if (oneHotNext == '0) begin
      oneHotNext[`MEM_NOP] = 1'b1;
    end
    // Failed conditional fetch becomes NOP here and nowhere else
    if (oneHotNext[`MEM_COND_FETCH] && !testSatisfied) begin
      oneHotNext[`MEM_COND_FETCH] = 1'b0;
      oneHotNext[`MEM_NOP] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else if (uwReady) begin
      decValid <= uwValid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      funcOneHot <= oneHotNext;
      decMagic <= magic;
      decAdWord <= adWord;
      decVma <= vma;
      decUserMode <= userMode;
      decPublicMode <= publicMode;
      decPrevEnable <= prevEnable;
      decPcSection <= pcSection;
    end
  end

  // Downstream relies on exactly one function per word
  oneFuncPerWord: assert property (
    @(posedge clk) disable iff (!rstN)
    decValid |-> $onehot(funcOneHot)
  );

endmodule

`default_nettype wire

// ==== cycleContext/cycleContext.sv ====
`default_nettype none

`include "memCtl_macros.svh"

module cycleContext (
  input  logic clk,
  input  logic rstN,
  input  logic decValid,
  output logic decReady,
  input  logic [`FUNC_CNT-1:0] funcOneHot,
  input  memCtlPkg::magicU magic,
  input  logic [`AD_W-1:0] adWord,
  input  logic [`VMA_W-1:0] vma,
  input  logic userMode,
  input  logic publicMode,
  input  logic prevEnable,
  input  logic [`SECTION_W-1:0] pcSection,
  output logic ctxValid,
  input  logic ctxReady,
  output logic read,
  output logic write,
  output logic pause,
  output logic fetch,
  output logic user,
  output logic public,
  output logic previous,
  output logic phys,
  output logic adrErr,
  output logic [`VMA_W-1:0] address
);

  logic isNop;
  logic eaCalc;
  logic adFunc;
  logic specCycle;
  logic readNext;
  logic writeNext;
  logic pauseNext;
  logic fetchNext;
  logic userNext;
  logic publicNext;
  logic longRef;
  logic [`SECTION_W-1:0] vmaSection;
  logic loadEn;

  assign isNop = funcOneHot[`MEM_NOP];
  assign eaCalc = funcOneHot[`MEM_EA_CALC];
  assign adFunc = funcOneHot[`MEM_AD_FUNC];
  assign specCycle = funcOneHot[`MEM_SPEC];

  assign decReady = ~ctxValid | ctxReady;
  assign loadEn = decValid & decReady & ~isNop;

  always_comb begin
    readNext = funcOneHot[`MEM_READ] | funcOneHot[`MEM_RPW] | eaCalc | specCycle |
               (adFunc & adWord[`AD_READ]);
    writeNext = funcOneHot[`MEM_WRITE] | funcOneHot[`MEM_RPW] |
                (adFunc & adWord[`AD_WRITE]);
    pauseNext = funcOneHot[`MEM_RPW] | (adFunc & adWord[`AD_PAUSE]);
    // Cond fetch bit only survives decode when the test passed
    fetchNext = funcOneHot[`MEM_FETCH] | funcOneHot[`MEM_COND_FETCH];

    if (adFunc) begin
      userNext = adWord[`AD_USER];
      publicNext = adWord[`AD_PUBLIC];
    end else begin
      // Executive cycle runs in kernel space
      userNext = userMode & ~(specCycle & magic.spec.execCycle);
      publicNext = publicMode & userNext;
    end

    longRef = (eaCalc & magic.ea.longEn) | (adFunc & adWord[`AD_LONG]);
  end

  assign vmaSection = vma[`VMA_W-1:`OFFSET_W];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctxValid <= 1'b0;
    end else if (decReady) begin
      // NOP words are consumed here and never reach the MBox
      ctxValid <= decValid & ~isNop;
    end
  end

  always_ff @(posedge clk) begin
    if (loadEn) begin
      read <= readNext;
      write <= writeNext;
      pause <= pauseNext;
      fetch <= fetchNext;
      user <= userNext;
      public <= publicNext;
      previous <= eaCalc & magic.ea.prevEn & prevEnable;
      phys <= specCycle & magic.spec.physRef;
      adrErr <= longRef & (vmaSection >= `SECTION_LIMIT);
      // Short reference stays in the PC section
      address <= longRef ? vma : {pcSection, vma[`OFFSET_W-1:0]};
    end
  end

endmodule

`default_nettype wire

// ==== logic/mboxRequest.sv ====
`default_nettype none

`include "memCtl_macros.svh"

module mboxRequest (
  input  logic clk,
  input  logic rstN,
  input  logic ctxValid,
  output logic ctxReady,
  input  logic read,
  input  logic write,
  input  logic pause,
  input  logic fetch,
  input  logic user,
  input  logic public,
  input  logic previous,
  input  logic phys,
  input  logic adrErr,
  input  logic [`VMA_W-1:0] address,
  input  logic userMode,
  input  logic publicMode,
  input  logic prevEnable,
  output logic reqValid,
  input  logic reqReady,
  output logic reqRead,
  output logic reqWrite,
  output logic reqPause,
  output logic reqFetch,
  output logic reqUser,
  output logic reqPublic,
  output logic reqPrevious,
  output logic reqPhys,
  output logic reqAdrErr,
  output logic [`VMA_W-1:0] reqAddr,
  input  logic statusSel,
  output logic [`STATUS_W-1:0] statusWord
);

  logic [`STATUS_W-1:0] heldCopy;
  logic [`STATUS_W-1:0] modeWord;
  logic reqDone;

  assign ctxReady = ~reqValid | reqReady;
  assign reqDone = reqValid & reqReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      reqValid <= 1'b0;
    end else if (ctxReady) begin
      reqValid <= ctxValid;
    end
  end

  always_ff @(posedge clk) begin
    if (ctxValid && ctxReady) begin
      reqRead <= read;
      reqWrite <= write;
      reqPause <= pause;
      reqFetch <= fetch;
      reqUser <= user;
      reqPublic <= public;
      reqPrevious <= previous;
      reqPhys <= phys;
      reqAdrErr <= adrErr;
      reqAddr <= address;
    end
  end

  // Snapshot of the last request the MBox took
  always_ff @(posedge clk) begin
    if (!rstN) begin
      heldCopy <= '0;
    end else if (reqDone) begin
      heldCopy <= {reqRead, reqWrite, reqPause, reqFetch, reqUser, reqPublic,
                   reqPrevious, reqPhys, reqAdrErr, 3'b000};
    end
  end

  assign modeWord = {{(`STATUS_W-3){1'b0}}, userMode, publicMode, prevEnable};
  assign statusWord = statusSel ? heldCopy : modeWord;

  // Stalled request must not change under the MBox
  reqHeldWhileStalled: assert property (
    @(posedge clk) disable iff (!rstN)
    (reqValid && !reqReady) |=> reqValid && $stable({reqRead, reqWrite, reqPause,
      reqFetch, reqUser, reqPublic, reqPrevious, reqPhys, reqAdrErr, reqAddr})
  );

endmodule

`default_nettype wire

// ==== logic/memCtl.sv ====
`default_nettype none

`include "memCtl_macros.svh"

module memCtl (
  input  logic clk,
  input  logic rstN,
  input  logic uwValid,
  output logic uwReady,
  input  logic [`MEM_FUNC_W-1:0] memField,
  input  memCtlPkg::magicU magic,
  input  logic [`AD_W-1:0] adWord,
  input  logic [`VMA_W-1:0] vma,
  input  logic testSatisfied,
  input  logic userMode,
  input  logic publicMode,
  input  logic prevEnable,
  input  logic [`SECTION_W-1:0] pcSection,
  output logic reqValid,
  input  logic reqReady,
  output logic reqRead,
  output logic reqWrite,
  output logic reqPause,
  output logic reqFetch,
  output logic reqUser,
  output logic reqPublic,
  output logic reqPrevious,
  output logic reqPhys,
  output logic reqAdrErr,
  output logic [`VMA_W-1:0] reqAddr,
  input  logic statusSel,
  output logic [`STATUS_W-1:0] statusWord
);

  // Decode to context stage
  logic decValid;
  logic decReady;
  logic [`FUNC_CNT-1:0] funcOneHot;
  memCtlPkg::magicU decMagic;
  logic [`AD_W-1:0] decAdWord;
  logic [`VMA_W-1:0] decVma;
  logic decUserMode;
  logic decPublicMode;
  logic decPrevEnable;
  logic [`SECTION_W-1:0] decPcSection;

  // Context to request stage
  logic ctxValid;
  logic ctxReady;
  logic ctxRead;
  logic ctxWrite;
  logic ctxPause;
  logic ctxFetch;
  logic ctxUser;
  logic ctxPublic;
  logic ctxPrevious;
  logic ctxPhys;
  logic ctxAdrErr;
  logic [`VMA_W-1:0] ctxAddress;

  memFuncDecode memFuncDecode_i (
    .clk(clk),
    .rstN(rstN),
    .uwValid(uwValid),
    .uwReady(uwReady),
    .memField(memField),
    .magic(magic),
    .adWord(adWord),
    .vma(vma),
    .testSatisfied(testSatisfied),
    .userMode(userMode),
    .publicMode(publicMode),
    .prevEnable(prevEnable),
    .pcSection(pcSection),
    .decValid(decValid),
    .decReady(decReady),
    .funcOneHot(funcOneHot),
    .decMagic(decMagic),
    .decAdWord(decAdWord),
    .decVma(decVma),
    .decUserMode(decUserMode),
    .decPublicMode(decPublicMode),
    .decPrevEnable(decPrevEnable),
    .decPcSection(decPcSection)
  );

  cycleContext cycleContext_i (
    .clk(clk),
    .rstN(rstN),
    .decValid(decValid),
    .decReady(decReady),
    .funcOneHot(funcOneHot),
    .magic(decMagic),
    .adWord(decAdWord),
    .vma(decVma),
    .userMode(decUserMode),
    .publicMode(decPublicMode),
    .prevEnable(decPrevEnable),
    .pcSection(decPcSection),
    .ctxValid(ctxValid),
    .ctxReady(ctxReady),
    .read(ctxRead),
    .write(ctxWrite),
    .pause(ctxPause),
    .fetch(ctxFetch),
    .user(ctxUser),
    .public(ctxPublic),
    .previous(ctxPrevious),
    .phys(ctxPhys),
    .adrErr(ctxAdrErr),
    .address(ctxAddress)
  );

  // Status shows live mode inputs, not the sampled ones
  mboxRequest mboxRequest_i (
    .clk(clk),
    .rstN(rstN),
    .ctxValid(ctxValid),
    .ctxReady(ctxReady),
    .read(ctxRead),
    .write(ctxWrite),
    .pause(ctxPause),
    .fetch(ctxFetch),
    .user(ctxUser),
    .public(ctxPublic),
    .previous(ctxPrevious),
    .phys(ctxPhys),
    .adrErr(ctxAdrErr),
    .address(ctxAddress),
    .userMode(userMode),
    .publicMode(publicMode),
    .prevEnable(prevEnable),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .reqRead(reqRead),
    .reqWrite(reqWrite),
    .reqPause(reqPause),
    .reqFetch(reqFetch),
    .reqUser(reqUser),
    .reqPublic(reqPublic),
    .reqPrevious(reqPrevious),
    .reqPhys(reqPhys),
    .reqAdrErr(reqAdrErr),
    .reqAddr(reqAddr),
    .statusSel(statusSel),
    .statusWord(statusWord)
  );

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
`default_nettype none

module clockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Four rising edges under reset, released away from the active edge
  initial begin
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/memCtlTb.sv ====
`default_nettype none

`include "memCtl_macros.svh"

module memCtlTb;

  localparam int ROWS = 16;
  localparam int LIMIT = 4 * ROWS + 50;
  localparam int EXP_W = 9 + `VMA_W;

  logic clk;
  logic rstN;
  logic uwValid;
  logic uwReady;
  logic [`MEM_FUNC_W-1:0] memField;
  memCtlPkg::magicU magic;
  logic [`AD_W-1:0] adWord;
  logic [`VMA_W-1:0] vma;
  logic testSatisfied;
  logic userMode;
  logic publicMode;
  logic prevEnable;
  logic [`SECTION_W-1:0] pcSection;
  logic reqValid;
  logic reqReady;
  logic reqRead;
  logic reqWrite;
  logic reqPause;
  logic reqFetch;
  logic reqUser;
  logic reqPublic;
  logic reqPrevious;
  logic reqPhys;
  logic reqAdrErr;
  logic [`VMA_W-1:0] reqAddr;
  logic statusSel;
  logic [`STATUS_W-1:0] statusWord;

  // Stimulus table and the expectations derived from it
  logic [`MEM_FUNC_W-1:0] funcTab [ROWS];
  memCtlPkg::magicU magicTab [ROWS];
  logic [`AD_W-1:0] adTab [ROWS];
  logic [`VMA_W-1:0] vmaTab [ROWS];
  logic testTab [ROWS];
  logic [2:0] modeTab [ROWS];
  logic [`SECTION_W-1:0] pcTab [ROWS];
  logic hasReqTab [ROWS];
  logic [EXP_W-1:0] expTab [ROWS];

  logic [EXP_W-1:0] expQ [$];
  int accQ [$];
  logic [EXP_W-1:0] curExp;
  logic curHasReq;
  logic [EXP_W-1:0] lastDone;
  int passNum;
  int passStart;
  int cycles;
  bit fullSeen;

  clockGen clockGen_i (
    .clk(clk),
    .rstN(rstN)
  );

  memCtl memCtl_i (
    .clk(clk), .rstN(rstN),
    .uwValid(uwValid), .uwReady(uwReady),
    .memField(memField), .magic(magic), .adWord(adWord), .vma(vma),
    .testSatisfied(testSatisfied), .userMode(userMode), .publicMode(publicMode),
    .prevEnable(prevEnable), .pcSection(pcSection),
    .reqValid(reqValid), .reqReady(reqReady),
    .reqRead(reqRead), .reqWrite(reqWrite), .reqPause(reqPause), .reqFetch(reqFetch),
    .reqUser(reqUser), .reqPublic(reqPublic), .reqPrevious(reqPrevious),
    .reqPhys(reqPhys), .reqAdrErr(reqAdrErr), .reqAddr(reqAddr),
    .statusSel(statusSel), .statusWord(statusWord)
  );

  task automatic stopWithFailure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] want);
    if (got !== want) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
      stopWithFailure();
    end
  endtask

  function automatic logic [`AD_W-1:0] adBits(input logic r, input logic w, input logic p,
                                              input logic u, input logic pb, input logic lg);
    logic [`AD_W-1:0] word;
    word = '0;
    word[`AD_READ] = r;
    word[`AD_WRITE] = w;
    word[`AD_PAUSE] = p;
    word[`AD_USER] = u;
    word[`AD_PUBLIC] = pb;
    word[`AD_LONG] = lg;
    return word;
  endfunction

  task automatic setRow(input int idx, input logic [`MEM_FUNC_W-1:0] f,
                        input logic [`MAGIC_W-1:0] mg, input logic [`AD_W-1:0] ad,
                        input logic [`VMA_W-1:0] v, input logic ts, input logic [2:0] mode,
                        input logic [`SECTION_W-1:0] pcs);
    funcTab[idx] = f;
    magicTab[idx] = mg;
    adTab[idx] = ad;
    vmaTab[idx] = v;
    testTab[idx] = ts;
    modeTab[idx] = mode;
    pcTab[idx] = pcs;
  endtask

  // Expected request per memory function
  // Mode bits are {user, public, prevEnable}
  task automatic refModel(input logic [`MEM_FUNC_W-1:0] f, input memCtlPkg::magicU m,
                          input logic [`AD_W-1:0] ad, input logic [`VMA_W-1:0] v,
                          input logic ts, input logic [2:0] mode,
                          input logic [`SECTION_W-1:0] pcs,
                          output logic hasReq, output logic [EXP_W-1:0] expOut);
    logic rd, wr, pa, fe, us, pu, pr, ph, lg, err;
    logic [`VMA_W-1:0] addr;
    {rd, wr, pa, fe, pr, ph, lg} = '0;
    us = mode[2];
    hasReq = 1'b1;
    case (f)
      `MEM_READ: rd = 1'b1;
      `MEM_WRITE: wr = 1'b1;
      `MEM_RPW: {rd, wr, pa} = 3'b111;
      `MEM_FETCH: fe = 1'b1;
      `MEM_COND_FETCH: begin
        fe = ts;
        hasReq = ts;
      end
      `MEM_EA_CALC: begin
        rd = 1'b1;
        pr = m.ea.prevEn & mode[0];
        lg = m.ea.longEn;
      end
      `MEM_AD_FUNC: begin
        rd = ad[`AD_READ];
        wr = ad[`AD_WRITE];
        pa = ad[`AD_PAUSE];
        us = ad[`AD_USER];
        lg = ad[`AD_LONG];
      end
      `MEM_SPEC: begin
        rd = 1'b1;
        if (m.spec.execCycle) us = 1'b0;
        ph = m.spec.physRef;
      end
      default: hasReq = 1'b0;
    endcase
    pu = (f == `MEM_AD_FUNC) ? ad[`AD_PUBLIC] : (mode[1] & us);
    addr = lg ? v : {pcs, v[`OFFSET_W-1:0]};
    err = lg && (v[`VMA_W-1:`OFFSET_W] >= `SECTION_LIMIT);
    expOut = {rd, wr, pa, fe, us, pu, pr, ph, err, addr};
  endtask

  task automatic buildTable();
    setRow(0, `MEM_READ, 9'h000, '0, {12'h005, 18'h01234}, 1'b0, 3'b110, 12'h003);
    setRow(1, `MEM_WRITE, 9'h000, '0, {12'h002, 18'h00777}, 1'b0, 3'b010, 12'h003);
    setRow(2, `MEM_RPW, 9'h1ff, '0, {12'h011, 18'h2aaaa}, 1'b0, 3'b111, 12'h001);
    setRow(3, `MEM_FETCH, 9'h000, '0, {12'h000, 18'h00040}, 1'b0, 3'b100, 12'h006);
    setRow(4, `MEM_NOP, 9'h000, '0, {12'h001, 18'h00001}, 1'b1, 3'b111, 12'h001);
    setRow(5, `MEM_COND_FETCH, 9'h000, '0, {12'h003, 18'h10000}, 1'b1, 3'b110, 12'h002);
    setRow(6, `MEM_COND_FETCH, 9'h000, '0, {12'h003, 18'h10001}, 1'b0, 3'b110, 12'h002);
    // EA calc with a long reference in the last implemented section
    setRow(7, `MEM_EA_CALC, 9'h180, '0, {12'h01f, 18'h3ffff}, 1'b0, 3'b111, 12'h005);
    setRow(8, `MEM_EA_CALC, 9'h180, '0, {12'h020, 18'h00100}, 1'b0, 3'b110, 12'h005);
    setRow(9, `MEM_EA_CALC, 9'h040, '0, {12'h7ff, 18'h00200}, 1'b0, 3'b001, 12'h004);
    setRow(10, `MEM_AD_FUNC, 9'h000, adBits(1, 0, 0, 1, 1, 1), {12'h040, 18'h00300},
           1'b0, 3'b000, 12'h004);
    setRow(11, `MEM_AD_FUNC, 9'h1ff, adBits(0, 1, 1, 0, 0, 0), {12'habc, 18'h00400},
           1'b0, 3'b110, 12'h007);
    // Spec cycles with and without the executive bit
    setRow(12, `MEM_SPEC, 9'h100, '0, {12'h009, 18'h00500}, 1'b0, 3'b110, 12'h008);
    setRow(13, `MEM_SPEC, 9'h080, '0, {12'h009, 18'h00600}, 1'b0, 3'b110, 12'h008);
    setRow(14, 4'hf, 9'h000, '0, {12'h001, 18'h00700}, 1'b1, 3'b111, 12'h001);
    setRow(15, `MEM_READ, 9'h000, '0, {12'h00a, 18'h00800}, 1'b0, 3'b010, 12'h00b);
    for (int i = 0; i < ROWS; i++) begin
      refModel(funcTab[i], magicTab[i], adTab[i], vmaTab[i], testTab[i], modeTab[i],
               pcTab[i], hasReqTab[i], expTab[i]);
    end
  endtask

  task automatic applyRow(input int idx);
    @(negedge clk);
    uwValid = 1'b1;
    memField = funcTab[idx];
    magic = magicTab[idx];
    adWord = adTab[idx];
    vma = vmaTab[idx];
    testSatisfied = testTab[idx];
    {userMode, publicMode, prevEnable} = modeTab[idx];
    pcSection = pcTab[idx];
    curExp = expTab[idx];
    curHasReq = hasReqTab[idx];
    do @(posedge clk); while (!uwReady);
  endtask

  task automatic runPass(input int p);
    @(negedge clk);
    passNum = p;
    passStart = cycles;
    for (int i = 0; i < ROWS; i++) begin
      applyRow(i);
    end
    @(negedge clk);
    uwValid = 1'b0;
    curHasReq = 1'b0;
    while (expQ.size() != 0) @(negedge clk);
    // Idle cycles to catch a stray request
    repeat (4) @(negedge clk);
  endtask

  // Output side stalls and status select
  initial begin
    int seed;
    int rnd;
    seed = 32'h018c_5d26;
    reqReady = 1'b1;
    statusSel = 1'b1;
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      if (passNum == 2) begin
        reqReady = (cycles - passStart < 8) ? 1'b0 : rnd[0];
        statusSel = rnd[1];
      end else begin
        reqReady = 1'b1;
        statusSel = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    logic [EXP_W-1:0] want;
    int acc;
    if (rstN) begin
      if (cycles - passStart >= LIMIT) begin
        $display("Timeout: pass %0d did not finish within %0d cycles", passNum, LIMIT);
        stopWithFailure();
      end
      if (statusSel) begin
        checkValue("statusWord", 64'(statusWord), 64'({lastDone[EXP_W-1:`VMA_W], 3'b000}));
      end else begin
        checkValue("statusWord", 64'(statusWord),
                   64'({9'b0, userMode, publicMode, prevEnable}));
      end
      if (reqValid && reqReady) begin
        if (expQ.size() == 0) begin
          $display("A request appeared that no accepted word should produce");
          stopWithFailure();
        end
        want = expQ.pop_front();
        acc = accQ.pop_front();
        checkValue("reqRead", 64'(reqRead), 64'(want[`VMA_W+8]));
        checkValue("reqWrite", 64'(reqWrite), 64'(want[`VMA_W+7]));
        checkValue("reqPause", 64'(reqPause), 64'(want[`VMA_W+6]));
        checkValue("reqFetch", 64'(reqFetch), 64'(want[`VMA_W+5]));
        checkValue("reqUser", 64'(reqUser), 64'(want[`VMA_W+4]));
        checkValue("reqPublic", 64'(reqPublic), 64'(want[`VMA_W+3]));
        checkValue("reqPrevious", 64'(reqPrevious), 64'(want[`VMA_W+2]));
        checkValue("reqPhys", 64'(reqPhys), 64'(want[`VMA_W+1]));
        checkValue("reqAdrErr", 64'(reqAdrErr), 64'(want[`VMA_W]));
        checkValue("reqAddr", 64'(reqAddr), 64'(want[`VMA_W-1:0]));
        if (passNum == 1) begin
          checkValue("reqValid latency", 64'(cycles - acc), 64'd3);
        end
        lastDone = want;
      end
      if (uwValid && passNum == 1) begin
        checkValue("uwReady", 64'(uwReady), 64'd1);
      end
      if (uwValid && !uwReady) fullSeen = 1'b1;
      if (uwValid && uwReady && curHasReq) begin
        expQ.push_back(curExp);
        accQ.push_back(cycles);
      end
      cycles = cycles + 1;
    end
  end

  initial begin
    uwValid = 1'b0;
    memField = '0;
    magic = '0;
    adWord = '0;
    vma = '0;
    testSatisfied = 1'b0;
    userMode = 1'b0;
    publicMode = 1'b0;
    prevEnable = 1'b0;
    pcSection = '0;
    curExp = '0;
    curHasReq = 1'b0;
    lastDone = '0;
    passNum = 0;
    passStart = 0;
    cycles = 0;
    fullSeen = 1'b0;
    buildTable();
    @(posedge rstN);
    runPass(1);
    runPass(2);
    if (!fullSeen) begin
      $display("uwReady never fell while the output side was stalled");
      stopWithFailure();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/memCtlPkg.sv
logic/memFuncDecode.sv
cycleContext/cycleContext.sv
logic/mboxRequest.sv
logic/memCtl.sv
test/clockGen.sv
test/memCtlTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the memCtl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=memCtlTb

if ! verilator --binary --timing --assert -f project.f --top-module "$TOP" -o "$TOP"; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./obj_dir/$TOP" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
